// ==== filelist.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/pipe_reg.sv
rtl/mem_stage.sv
rtl/data_ram.sv
rtl/csr_file.sv
rtl/mem_subsys_top.sv
verification/tb_clkgen.sv
verification/mem_subsys_asserts.sv
verification/mem_subsys_tb.sv

// ==== rtl/csr_file.sv ====
`timescale 1ns/10ps
`include "mem_consts.svh"

module csr_file (
    input  logic               clk,
    input  logic               arst_n,
    input  mem_pkg::csr_addr_t rd_addr,
    output logic [`DATA_W-1:0] rd_data,
    input  logic               we,
    input  mem_pkg::csr_addr_t wr_addr,
    input  logic [`DATA_W-1:0] wr_data,
    output logic [`CNT_W-1:0]  cnt
);

    logic [`DATA_W-1:0] crmd;
    logic [`DATA_W-1:0] save [4];
    logic [`DATA_W-1:0] tid;

    always_comb begin
        case (rd_addr)
            `CSR_CRMD:  rd_data = crmd;
            `CSR_ESTAT: rd_data = '0;       // no interrupt sources here.
            `CSR_SAVE0: rd_data = save[0];
            `CSR_SAVE1: rd_data = save[1];
            `CSR_SAVE2: rd_data = save[2];
            `CSR_SAVE3: rd_data = save[3];
            `CSR_TID:   rd_data = tid;
            default:    rd_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            crmd <= `CRMD_RESET;
            save <= '{default: '0};
            tid  <= `TID_RESET;
        end else if (we) begin
            case (wr_addr)
                `CSR_CRMD:  crmd    <= wr_data;
                `CSR_SAVE0: save[0] <= wr_data;
                `CSR_SAVE1: save[1] <= wr_data;
                `CSR_SAVE2: save[2] <= wr_data;
                `CSR_SAVE3: save[3] <= wr_data;
                `CSR_TID:   tid     <= wr_data;
                default: ;                      // estat and unknown ignore writes.
            endcase
        end
    end

    // stable counter.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/data_ram.sv ====
`timescale 1ns/10ps
`include "mem_consts.svh"

module data_ram (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  logic [`RAM_AW-1:0]   wb_adr,
    input  logic [`DATA_W/8-1:0] wb_sel,
    input  logic [`DATA_W-1:0]   wb_dat_w,
    output logic [`DATA_W-1:0]   wb_dat_r,
    output logic                 wb_ack
);

    logic [`DATA_W-1:0] mem [2**`RAM_AW];
    logic               req;

    initial begin
        for (int i = 0; i < 2**`RAM_AW; i++) begin
            mem[i] = '0;
        end
    end

    // new request only while no ack is out.
    assign req = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= req;   // one cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (req && wb_we) begin
            for (int b = 0; b < `DATA_W/8; b++) begin
                if (wb_sel[b]) begin
                    mem[wb_adr][8*b +: 8] <= wb_dat_w[8*b +: 8];
                end
            end
        end
        if (req) begin
            wb_dat_r <= mem[wb_adr];   // lines up with ack.
        end
    end

endmodule

// ==== rtl/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// datapath widths.
`define DATA_W      32
`define REG_AW      5
`define CSR_AW      14
`define CNT_W       64

// data ram is word addressed.
`define RAM_AW      8

// csr numbers.
`define CSR_CRMD    14'h000
`define CSR_ESTAT   14'h005
`define CSR_SAVE0   14'h030
`define CSR_SAVE1   14'h031
`define CSR_SAVE2   14'h032
`define CSR_SAVE3   14'h033
`define CSR_TID     14'h040

// reset values.
`define CRMD_RESET  32'h0000_0008
`define TID_RESET   32'h0000_0042

`endif

// ==== rtl/mem_pkg.sv ====
`include "mem_consts.svh"

package mem_pkg;

    typedef logic [`CSR_AW-1:0] csr_addr_t;

    typedef enum logic [4:0] {
        NOP     = 5'd0,
        ALU     = 5'd1,   // result passes straight through.
        LD_B    = 5'd2,
        LD_BU   = 5'd3,
        LD_H    = 5'd4,
        LD_HU   = 5'd5,
        LD_W    = 5'd6,
        ST_B    = 5'd7,
        ST_H    = 5'd8,
        ST_W    = 5'd9,
        CSRRD   = 5'd10,
        CSRWR   = 5'd11,
        CSRXCHG = 5'd12,
        RDCNTID = 5'd13,
        RDCNTVL = 5'd14,
        RDCNTVH = 5'd15
    } aluop_t;

    // execute to memory payload.
    typedef struct packed {
        logic               valid;
        aluop_t             op;
        logic [`DATA_W-1:0] mem_addr;
        logic [`DATA_W-1:0] st_data;
        logic               rd_en;
        logic [`REG_AW-1:0] rd_addr;
        logic [`DATA_W-1:0] rd_data;
        csr_addr_t          csr_addr;
        logic [`DATA_W-1:0] csr_wdata;
        logic [`DATA_W-1:0] csr_mask;
    } ex_mem_t;

    // memory to writeback payload.
    typedef struct packed {
        logic               valid;
        logic               rd_en;
        logic [`REG_AW-1:0] rd_addr;
        logic [`DATA_W-1:0] rd_data;
        logic               csr_we;
        csr_addr_t          csr_addr;
        logic [`DATA_W-1:0] csr_wdata;
    } mem_wb_t;

endpackage

// ==== rtl/mem_stage.sv ====
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_stage (
    input  mem_pkg::ex_mem_t   ex_mem,
    output logic               pause,
    output mem_pkg::mem_wb_t   mem_wb,
    output logic               wb_cyc,
    output logic               wb_stb,
    output logic               wb_we,
    output logic [`RAM_AW-1:0] wb_adr,
    output logic [3:0]         wb_sel,
    output logic [`DATA_W-1:0] wb_dat_w,
    input  logic [`DATA_W-1:0] wb_dat_r,
    input  logic               wb_ack,
    output mem_pkg::csr_addr_t csr_rd_addr,
    input  logic [`DATA_W-1:0] csr_rd_data,
    input  logic               fwd_we,
    input  mem_pkg::csr_addr_t fwd_addr,
    input  logic [`DATA_W-1:0] fwd_data,
    input  logic [`CNT_W-1:0]  cnt
);
    import mem_pkg::*;

    logic               is_load;
    logic               is_store;
    logic               mem_req;
    logic               csr_rd_en;
    logic               csr_wr;
    logic [7:0]         ld_byte;
    logic [15:0]        ld_half;
    logic               half_ok;
    logic [`DATA_W-1:0] load_data;
    logic [`DATA_W-1:0] csr_old;
    logic [`DATA_W-1:0] rd_result;

    assign is_load  = ex_mem.op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W};
    assign is_store = ex_mem.op inside {ST_B, ST_H, ST_W};
    assign mem_req  = ex_mem.valid && (is_load || is_store);

    // request held until the slave acks.
    assign wb_cyc = mem_req;
    assign wb_stb = mem_req;
    assign wb_we  = mem_req && is_store;
    assign wb_adr = ex_mem.mem_addr[`RAM_AW+1:2];
    assign pause  = mem_req && !wb_ack;

    always_comb begin
        case (ex_mem.op)
            ST_B: begin
                wb_sel   = 4'b0001 << ex_mem.mem_addr[1:0];
                wb_dat_w = {4{ex_mem.st_data[7:0]}};
            end
            ST_H: begin
                wb_sel   = ex_mem.mem_addr[1] ? 4'b1100 : 4'b0011;
                wb_dat_w = {2{ex_mem.st_data[15:0]}};
            end
            default: begin
                wb_sel   = 4'b1111;   // word store and all loads.
                wb_dat_w = ex_mem.st_data;
            end
        endcase
    end

    // lane pick from the returned word.
    assign ld_byte = wb_dat_r[8*ex_mem.mem_addr[1:0] +: 8];
    assign ld_half = ex_mem.mem_addr[1] ? wb_dat_r[31:16] : wb_dat_r[15:0];
    assign half_ok = !ex_mem.mem_addr[0];

    always_comb begin
        case (ex_mem.op)
            LD_B:    load_data = {{24{ld_byte[7]}}, ld_byte};
            LD_BU:   load_data = {24'b0, ld_byte};
            LD_H:    load_data = half_ok ? {{16{ld_half[15]}}, ld_half} : '0;
            LD_HU:   load_data = half_ok ? {16'b0, ld_half} : '0;
            default: load_data = wb_dat_r;
        endcase
    end

    // rdcntid reads tid through the normal csr port.
    assign csr_rd_en   = ex_mem.op inside {CSRRD, CSRWR, CSRXCHG, RDCNTID};
    assign csr_wr      = ex_mem.valid && (ex_mem.op inside {CSRWR, CSRXCHG});
    assign csr_rd_addr = (ex_mem.op == RDCNTID) ? `CSR_TID : ex_mem.csr_addr;

    // a write sitting in writeback commits only at the next edge.
    assign csr_old = (fwd_we && fwd_addr == csr_rd_addr) ? fwd_data : csr_rd_data;

    always_comb begin
        if (is_load) begin
            rd_result = load_data;
        end else if (csr_rd_en) begin
            rd_result = csr_old;
        end else begin
            case (ex_mem.op)
                RDCNTVL: rd_result = cnt[31:0];
                RDCNTVH: rd_result = cnt[63:32];
                default: rd_result = ex_mem.rd_data;
            endcase
        end
    end

    always_comb begin
        mem_wb.valid    = ex_mem.valid;
        mem_wb.rd_en    = ex_mem.rd_en && !is_store;   // stores never write rd.
        mem_wb.rd_addr  = ex_mem.rd_addr;
        mem_wb.rd_data  = rd_result;
        mem_wb.csr_we   = csr_wr;
        mem_wb.csr_addr = ex_mem.csr_addr;
        if (ex_mem.op == CSRXCHG) begin
            mem_wb.csr_wdata = (csr_old & ~ex_mem.csr_mask)
                             | (ex_mem.csr_wdata & ex_mem.csr_mask);
        end else begin
            mem_wb.csr_wdata = ex_mem.csr_wdata;
        end
    end

endmodule

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_subsys_top (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               in_valid,
    input  mem_pkg::aluop_t    in_op,
    input  logic [`DATA_W-1:0] in_mem_addr,
    input  logic [`DATA_W-1:0] in_st_data,
    input  logic               in_rd_en,
    input  logic [`REG_AW-1:0] in_rd_addr,
    input  logic [`DATA_W-1:0] in_rd_data,
    input  mem_pkg::csr_addr_t in_csr_addr,
    input  logic [`DATA_W-1:0] in_csr_wdata,
    input  logic [`DATA_W-1:0] in_csr_mask,
    output logic               in_ready,
    output logic               wb_valid,
    output logic               wb_rd_en,
    output logic [`REG_AW-1:0] wb_rd_addr,
    output logic [`DATA_W-1:0] wb_rd_data
);
    import mem_pkg::*;

    ex_mem_t            ex_mem_d;
    ex_mem_t            ex_mem_q;
    mem_wb_t            mem_wb_d;
    mem_wb_t            mem_wb_q;
    logic               pause;
    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    logic [`RAM_AW-1:0] wb_adr;
    logic [3:0]         wb_sel;
    logic [`DATA_W-1:0] wb_dat_w;
    logic [`DATA_W-1:0] wb_dat_r;
    logic               wb_ack;
    csr_addr_t          csr_rd_addr;
    logic [`DATA_W-1:0] csr_rd_data;
    logic [`CNT_W-1:0]  cnt;

    assign ex_mem_d = '{valid: in_valid, op: in_op, mem_addr: in_mem_addr,
                        st_data: in_st_data, rd_en: in_rd_en, rd_addr: in_rd_addr,
                        rd_data: in_rd_data, csr_addr: in_csr_addr,
                        csr_wdata: in_csr_wdata, csr_mask: in_csr_mask};
    assign in_ready = !pause;

    assign wb_valid   = mem_wb_q.valid;
    assign wb_rd_en   = mem_wb_q.rd_en;
    assign wb_rd_addr = mem_wb_q.rd_addr;
    assign wb_rd_data = mem_wb_q.rd_data;

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk(clk), .arst_n(arst_n), .stall(pause), .bubble(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    mem_stage u_mem_stage (
        .ex_mem(ex_mem_q), .pause(pause), .mem_wb(mem_wb_d),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .csr_rd_addr(csr_rd_addr), .csr_rd_data(csr_rd_data),
        .fwd_we(mem_wb_q.csr_we), .fwd_addr(mem_wb_q.csr_addr),
        .fwd_data(mem_wb_q.csr_wdata), .cnt(cnt)
    );

    // a paused stage hands writeback a bubble.
    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk(clk), .arst_n(arst_n), .stall(1'b0), .bubble(pause),
        .d(mem_wb_d), .q(mem_wb_q)
    );

    data_ram u_data_ram (
        .clk(clk), .arst_n(arst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
        .wb_adr(wb_adr), .wb_sel(wb_sel), .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
    );

    csr_file u_csr_file (
        .clk(clk), .arst_n(arst_n), .rd_addr(csr_rd_addr), .rd_data(csr_rd_data),
        .we(mem_wb_q.csr_we), .wr_addr(mem_wb_q.csr_addr),
        .wr_data(mem_wb_q.csr_wdata), .cnt(cnt)
    );

endmodule

// ==== rtl/pipe_reg.sv ====
`timescale 1ns/10ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     stall,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= '0;
        end else if (stall) begin
            q <= q;           // hold current contents.
        end else if (bubble) begin
            q <= '0;          // valid drops with the rest.
        end else begin
            q <= d;
        end
    end

endmodule

// ==== verification/mem_subsys_asserts.sv ====
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_subsys_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               wb_cyc,
    input logic               wb_stb,
    input logic [`RAM_AW-1:0] wb_adr,
    input logic [3:0]         wb_sel,
    input logic [`DATA_W-1:0] wb_dat_w,
    input logic               wb_ack,
    input logic               in_ready
);

    a_stb_cyc: assert property (@(posedge clk) disable iff (!arst_n) wb_stb |-> wb_cyc)
        else $error("wb_stb high without wb_cyc");

    // request must hold until the slave answers.
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr) && $stable(wb_sel)
                              && $stable(wb_dat_w))
        else $error("wishbone request changed before ack");

    a_ack_stb: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |-> wb_stb)
        else $error("wb_ack without wb_stb");

    a_ack_pulse: assert property (@(posedge clk) disable iff (!arst_n) wb_ack |=> !wb_ack)
        else $error("wb_ack high on two consecutive cycles");

    a_pause: assert property (@(posedge clk) disable iff (!arst_n)
        wb_stb && !wb_ack |-> !in_ready)
        else $error("in_ready high while a request is pending");

endmodule

bind mem_subsys_top mem_subsys_asserts u_asserts (
    .clk(clk), .arst_n(arst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_adr(wb_adr),
    .wb_sel(wb_sel), .wb_dat_w(wb_dat_w), .wb_ack(wb_ack), .in_ready(in_ready)
);

// ==== verification/mem_subsys_tb.sv ====
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_subsys_tb;
    import mem_pkg::*;

    localparam logic [1:0] K_EXACT = 2'd0;   // rd_data compared.
    localparam logic [1:0] K_NONE  = 2'd1;   // store, no rd write.
    localparam logic [1:0] K_CNT   = 2'd2;   // counter value, must rise.

    typedef struct packed {
        aluop_t      op;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [4:0]  rd;
        csr_addr_t   csr;
        logic [31:0] wdata;
        logic [31:0] mask;
        logic [31:0] exp;
        logic [1:0]  kind;
    } row_t;

    logic               clk;
    logic               arst_n;
    logic               in_valid;
    aluop_t             in_op;
    logic [31:0]        in_mem_addr;
    logic [31:0]        in_st_data;
    logic               in_rd_en;
    logic [4:0]         in_rd_addr;
    logic [31:0]        in_rd_data;
    csr_addr_t          in_csr_addr;
    logic [31:0]        in_csr_wdata;
    logic [31:0]        in_csr_mask;
    logic               in_ready;
    logic               wb_valid;
    logic               wb_rd_en;
    logic [4:0]         wb_rd_addr;
    logic [31:0]        wb_rd_data;
    row_t               rows[$];
    row_t               exp_q[$];
    logic [31:0]        ram_m [2**`RAM_AW];
    logic [31:0]        csr_m [int];
    logic [31:0]        last_cnt = '0;

    tb_clkgen u_clkgen (.clk(clk), .arst_n(arst_n));

    mem_subsys_top DUT (
        .clk(clk), .arst_n(arst_n), .in_valid(in_valid), .in_op(in_op),
        .in_mem_addr(in_mem_addr), .in_st_data(in_st_data), .in_rd_en(in_rd_en),
        .in_rd_addr(in_rd_addr), .in_rd_data(in_rd_data), .in_csr_addr(in_csr_addr),
        .in_csr_wdata(in_csr_wdata), .in_csr_mask(in_csr_mask), .in_ready(in_ready),
        .wb_valid(wb_valid), .wb_rd_en(wb_rd_en), .wb_rd_addr(wb_rd_addr),
        .wb_rd_data(wb_rd_data)
    );

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // lane shifted down first, then extended.
    function automatic logic [31:0] load_ext(input aluop_t op, input logic [31:0] w,
                                             input logic [1:0] off);
        logic [31:0] s;
        s = w >> (8 * off);
        case (op)
            LD_B:    return {{24{s[7]}}, s[7:0]};
            LD_BU:   return s & 32'h0000_00ff;
            LD_H:    return off[0] ? 32'h0 : {{16{s[15]}}, s[15:0]};
            LD_HU:   return off[0] ? 32'h0 : s & 32'h0000_ffff;
            default: return w;
        endcase
    endfunction

    // bits under the mask come from the new value.
    function automatic logic [31:0] masked_merge(input logic [31:0] old,
                                                 input logic [31:0] val,
                                                 input logic [31:0] mask);
        logic [31:0] m;
        m = old;
        for (int b = 0; b < 32; b++) begin
            if (mask[b]) begin
                m[b] = val[b];
            end
        end
        return m;
    endfunction

    function automatic logic [31:0] csr_get(input csr_addr_t a);
        return csr_m.exists(a) ? csr_m[a] : 32'h0;
    endfunction

    task automatic csr_put(input csr_addr_t a, input logic [31:0] v);
        if (csr_m.exists(a) && a != `CSR_ESTAT) csr_m[a] = v;
    endtask

    task automatic add_row(input aluop_t op, input logic [31:0] addr, input logic [31:0] sdata,
                           input csr_addr_t csr, input logic [31:0] wdata,
                           input logic [31:0] mask);
        row_t        r;
        logic [7:0]  idx;
        logic [31:0] old;
        idx = addr[9:2];
        old = csr_get(op == RDCNTID ? csr_addr_t'(`CSR_TID) : csr);
        r.op    = op;
        r.addr  = addr;
        r.sdata = sdata;
        r.rd    = 5'(rows.size());
        r.csr   = csr;
        r.wdata = wdata;
        r.mask  = mask;
        r.exp   = old;     // csr ops return the old value.
        r.kind  = K_EXACT;
        case (op)
            ST_B: begin
                ram_m[idx][8*addr[1:0] +: 8] = sdata[7:0];
                r.kind = K_NONE;
            end
            ST_H: begin
                ram_m[idx][16*addr[1] +: 16] = sdata[15:0];
                r.kind = K_NONE;
            end
            ST_W: begin
                ram_m[idx] = sdata;
                r.kind = K_NONE;
            end
            LD_B, LD_BU, LD_H, LD_HU, LD_W: r.exp = load_ext(op, ram_m[idx], addr[1:0]);
            CSRRD, RDCNTID: ;
            CSRWR:   csr_put(csr, wdata);
            CSRXCHG: csr_put(csr, masked_merge(old, wdata, mask));
            RDCNTVL: r.kind = K_CNT;
            RDCNTVH: r.exp = 32'h0;
            default: r.exp = wdata;   // alu result passes through.
        endcase
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [31:0] a;
        logic [31:0] d;
        for (int i = 0; i < 2**`RAM_AW; i++) ram_m[i] = '0;
        csr_m[`CSR_CRMD]  = `CRMD_RESET;
        csr_m[`CSR_ESTAT] = 32'h0;
        csr_m[`CSR_SAVE0] = 32'h0;
        csr_m[`CSR_SAVE1] = 32'h0;
        csr_m[`CSR_SAVE2] = 32'h0;
        csr_m[`CSR_SAVE3] = 32'h0;
        csr_m[`CSR_TID]   = `TID_RESET;
        add_row(ST_W, 32'h10, 32'hdead_beef, 0, 0, 0);
        add_row(LD_W, 32'h10, 0, 0, 0, 0);
        for (int l = 0; l < 4; l++) begin
            add_row(ST_W, 32'h20, 32'h1122_3344, 0, 0, 0);
            add_row(ST_B, 32'h20 + l, 32'h0000_00a0 + l, 0, 0, 0);
            add_row(LD_W, 32'h20, 0, 0, 0, 0);
        end
        for (int l = 0; l < 4; l += 2) begin
            add_row(ST_H, 32'h24 + l, 32'h0000_c0de + l, 0, 0, 0);
            add_row(LD_W, 32'h24, 0, 0, 0, 0);
        end
        add_row(ST_W, 32'h40, 32'h80f1_7f82, 0, 0, 0);
        for (int l = 0; l < 4; l++) begin
            add_row(LD_B, 32'h40 + l, 0, 0, 0, 0);
            add_row(LD_BU, 32'h40 + l, 0, 0, 0, 0);
        end
        for (int l = 0; l < 3; l++) begin   // offset 1 is the misaligned half.
            add_row(LD_H, 32'h40 + l, 0, 0, 0, 0);
            add_row(LD_HU, 32'h40 + l, 0, 0, 0, 0);
        end
        for (int i = 0; i < 8; i++) begin
            a = $urandom & 32'h3fc;
            d = $urandom;
            add_row(ST_W, a, d, 0, 0, 0);
            add_row(ALU, 0, 0, 0, d ^ 32'h0000_ffff, 0);
            a = a | ($urandom & 32'h3);
            add_row(LD_B, a, 0, 0, 0, 0);
            add_row(LD_HU, a & ~32'h1, 0, 0, 0, 0);
        end
        add_row(CSRRD, 0, 0, `CSR_CRMD, 0, 0);
        add_row(CSRWR, 0, 0, `CSR_SAVE0, 32'h1234_5678, 0);
        add_row(CSRRD, 0, 0, `CSR_SAVE0, 0, 0);   // needs the writeback forward.
        add_row(ALU, 0, 0, 0, 32'h5a5a_0001, 0);
        add_row(CSRRD, 0, 0, `CSR_SAVE0, 0, 0);
        add_row(CSRWR, 0, 0, `CSR_SAVE1, 32'haaaa_5555, 0);
        add_row(CSRXCHG, 0, 0, `CSR_SAVE1, 32'h0f0f_0f0f, 32'h00ff_00ff);
        add_row(CSRRD, 0, 0, `CSR_SAVE1, 0, 0);
        add_row(RDCNTID, 0, 0, 0, 0, 0);
        add_row(CSRRD, 0, 0, `CSR_ESTAT, 0, 0);
        add_row(RDCNTVH, 0, 0, 0, 0, 0);
        add_row(RDCNTVL, 0, 0, 0, 0, 0);
        add_row(LD_W, 32'h10, 0, 0, 0, 0);
        add_row(RDCNTVL, 0, 0, 0, 0, 0);
    endtask

    task automatic apply_row(input row_t r);
        @(negedge clk);
        in_valid     = 1'b1;
        in_op        = r.op;
        in_mem_addr  = r.addr;
        in_st_data   = r.sdata;
        in_rd_en     = 1'b1;
        in_rd_addr   = r.rd;
        in_rd_data   = r.wdata;
        in_csr_addr  = r.csr;
        in_csr_wdata = r.wdata;
        in_csr_mask  = r.mask;
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        exp_q.push_back(r);   // accepted at this edge.
    endtask

    // writeback monitor, sampled mid-cycle.
    always @(negedge clk) begin
        row_t r;
        if (arst_n && wb_valid) begin
            if (exp_q.size() == 0) begin
                $display("writeback at %0t with no operation outstanding", $time);
                $display("FAIL: see errors above");
                $fatal(1, "extra writeback");
            end else begin
                r = exp_q.pop_front();
                check("wb_rd_addr", wb_rd_addr, r.rd);
                check("wb_rd_en", wb_rd_en, r.kind != K_NONE);
                if (r.kind == K_EXACT) begin
                    check("wb_rd_data", wb_rd_data, r.exp);
                end else if (r.kind == K_CNT) begin
                    check("wb_rd_data above last counter", wb_rd_data > last_cnt, 1);
                    last_cnt = wb_rd_data;
                end
            end
        end
    end

    initial begin
        int limit;
        #1;
        limit = rows.size() * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("timeout: writeback not finished after %0d cycles", limit);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        in_valid     = 1'b0;
        in_op        = ALU;
        in_mem_addr  = '0;
        in_st_data   = '0;
        in_rd_en     = 1'b0;
        in_rd_addr   = '0;
        in_rd_data   = '0;
        in_csr_addr  = '0;
        in_csr_wdata = '0;
        in_csr_mask  = '0;
        void'($urandom(32'h3fd4));
        build_table();
        wait (arst_n === 1'b1);
        check("in_ready", in_ready, 1);
        check("wb_valid", wb_valid, 0);
        foreach (rows[i]) apply_row(rows[i]);
        @(negedge clk);
        in_valid = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== verification/tb_clkgen.sv ====
`timescale 1ns/10ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period.
    end

    initial begin
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;            // released away from the active edge.
    end

endmodule
